// File: design/mem_pkg.sv
package mem_pkg;

    // lane count and datapath widths
    parameter int NUM_LANES  = 2;   // dual issue
    parameter int XLEN       = 32;  // data and address width
    parameter int REG_ADDR_W = 5;   // 32 integer registers
    parameter int EXC_W      = 5;   // flags gathered up to execute
    parameter int EXC_OUT_W  = EXC_W + 1;   // plus the commit-stage bit

    // op codes decoded here, anything else passes through
    typedef enum logic [7:0] {
        OP_OTHER = 8'h00,
        LDB      = 8'h20,   // signed byte
        LDH      = 8'h21,   // signed half
        LDW      = 8'h22,
        LDBU     = 8'h23,   // unsigned byte
        LDHU     = 8'h24,   // unsigned half
        LLW      = 8'h25    // load-linked word
    } mem_op_e;

    // one lane as it leaves execute
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        mem_op_e               op;
        logic [XLEN-1:0]       addr;        // effective address
        logic                  rf_we;
        logic [REG_ADDR_W-1:0] rf_waddr;
        logic [XLEN-1:0]       rf_wdata;    // execute result
        logic [EXC_W-1:0]      exc;
    } mem_lane_t;

    // one lane as it leaves the MEM/WB register
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       addr;
        logic                  rf_we;
        logic [REG_ADDR_W-1:0] rf_waddr;
        logic [XLEN-1:0]       rf_wdata;    // load data or forwarded result
        logic [EXC_OUT_W-1:0]  exc;         // bit 0 is the commit flag
    } wb_lane_t;

endpackage

// File: design/load_align.sv
module load_align (
    input  mem_pkg::mem_lane_t    lane_i,
    input  logic [mem_pkg::XLEN-1:0] dcache_rdata_i,
    input  logic                  dcache_data_ok_i,
    output mem_pkg::mem_lane_t    lane_o,
    output logic                  stall_o
);

    logic [7:0]               byte_sel;     // byte picked by addr[1:0]
    logic [15:0]              half_sel;     // half picked by addr[1]
    logic                     half_aligned;
    logic                     is_load;
    logic [mem_pkg::XLEN-1:0] load_data;

    // byte lane select from the cache word
    always_comb begin
        case (lane_i.addr[1:0])
            2'b00: byte_sel = dcache_rdata_i[7:0];
            2'b01: byte_sel = dcache_rdata_i[15:8];
            2'b10: byte_sel = dcache_rdata_i[23:16];
            default: byte_sel = dcache_rdata_i[31:24];
        endcase
    end

    assign half_sel     = lane_i.addr[1] ? dcache_rdata_i[31:16] : dcache_rdata_i[15:0];
    assign half_aligned = ~lane_i.addr[0];  // odd half address reads zero

    // decode and extend
    always_comb begin
        is_load   = 1'b1;
        load_data = '0;
        case (lane_i.op)
            mem_pkg::LDB: begin
                load_data = {{(mem_pkg::XLEN-8){byte_sel[7]}}, byte_sel};
            end
            mem_pkg::LDBU: begin
                load_data = {{(mem_pkg::XLEN-8){1'b0}}, byte_sel};
            end
            mem_pkg::LDH: begin
                if (half_aligned) begin
                    load_data = {{(mem_pkg::XLEN-16){half_sel[15]}}, half_sel};
                end
            end
            mem_pkg::LDHU: begin
                if (half_aligned) begin
                    load_data = {{(mem_pkg::XLEN-16){1'b0}}, half_sel};
                end
            end
            mem_pkg::LDW,
            mem_pkg::LLW: begin
                load_data = dcache_rdata_i;     // full word
            end
            default: begin
                is_load = 1'b0;
            end
        endcase
    end

    // a load waits here until the cache answers
    assign stall_o = is_load & ~dcache_data_ok_i;

    always_comb begin
        lane_o = lane_i;    // control and address go through
        if (is_load) begin
            lane_o.rf_wdata = dcache_data_ok_i ? load_data : '0;
        end
    end

endmodule

// File: design/mem_wb_reg.sv
module mem_wb_reg #(
    parameter int NUM_LANES = mem_pkg::NUM_LANES
) (
    input  logic                                 clk,
    input  logic                                 rst_i,
    input  mem_pkg::mem_lane_t [NUM_LANES-1:0]   lanes_i,
    input  logic               [NUM_LANES-1:0]   stall_i,
    output logic                                 pause_o,
    output mem_pkg::wb_lane_t  [NUM_LANES-1:0]   wb_o
);

    logic              [NUM_LANES-1:0] exc_any;    // per lane, any flag set
    mem_pkg::wb_lane_t [NUM_LANES-1:0] wb_next;

    // repack each lane for write-back
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            exc_any[i]          = |lanes_i[i].exc;
            wb_next[i].valid    = lanes_i[i].valid;
            wb_next[i].pc       = lanes_i[i].pc;
            wb_next[i].addr     = lanes_i[i].addr;
            wb_next[i].rf_we    = lanes_i[i].rf_we;
            wb_next[i].rf_waddr = lanes_i[i].rf_waddr;
            wb_next[i].rf_wdata = lanes_i[i].rf_wdata;
            wb_next[i].exc      = {lanes_i[i].exc, 1'b0};   // commit bit is zero
        end
    end

    // an exception in either lane lets the bundle through
    assign pause_o = (|stall_i) & ~(|exc_any);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_o <= '0;
        end else if (pause_o) begin
            wb_o <= '0;         // bubble while the cache is busy
        end else begin
            wb_o <= wb_next;
        end
    end

endmodule

// File: design/mem_stage.sv
module mem_stage #(
    parameter int NUM_LANES = mem_pkg::NUM_LANES
) (
    input  logic                                 clk,
    input  logic                                 rst_i,
    input  mem_pkg::mem_lane_t [NUM_LANES-1:0]   lanes_i,
    input  logic [mem_pkg::XLEN-1:0]             dcache_rdata_i,    // shared read port
    input  logic                                 dcache_data_ok_i,
    output logic                                 pause_o,           // to pipeline control
    output mem_pkg::wb_lane_t  [NUM_LANES-1:0]   wb_o
);

    mem_pkg::mem_lane_t [NUM_LANES-1:0] aligned;     // lanes with load data in place
    logic               [NUM_LANES-1:0] lane_stall;

    // one aligner per issue lane
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        load_align u_load_align (
            .lane_i           (lanes_i[g]),
            .dcache_rdata_i   (dcache_rdata_i),
            .dcache_data_ok_i (dcache_data_ok_i),
            .lane_o           (aligned[g]),
            .stall_o          (lane_stall[g])
        );
    end

    mem_wb_reg #(
        .NUM_LANES (NUM_LANES)
    ) u_mem_wb_reg (
        .clk      (clk),
        .rst_i    (rst_i),
        .lanes_i  (aligned),
        .stall_i  (lane_stall),
        .pause_o  (pause_o),
        .wb_o     (wb_o)
    );

endmodule

// File: verification/mem_stage_asserts.sv
module mem_stage_asserts #(
    parameter int NUM_LANES = mem_pkg::NUM_LANES
) (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  mem_pkg::mem_lane_t [NUM_LANES-1:0] lanes_i,
    input  logic                               pause_i,
    input  mem_pkg::wb_lane_t  [NUM_LANES-1:0] wb_i
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [NUM_LANES-1:0] wb_valid;
    logic [NUM_LANES-1:0] wb_we;
    logic                 exc_seen;     // any lane flags an exception

    always_comb begin
        exc_seen = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            wb_valid[i] = wb_i[i].valid;
            wb_we[i]    = wb_i[i].rf_we;
            exc_seen    = exc_seen | (|lanes_i[i].exc);
        end
    end

    reset_clears: assert property (@(posedge clk_i) rst_i |=> (wb_valid == '0 && wb_we == '0))
        else $error("wb_o valid or rf_we still set after a reset edge");

    pause_makes_bubble: assert property (@(posedge clk_i) disable iff (rst_i)
        pause_i |=> (wb_valid == '0))
        else $error("wb_o carries a valid lane after a paused cycle");

    exc_blocks_pause: assert property (@(posedge clk_i) exc_seen |-> !pause_i)
        else $error("pause_o high while a lane carries an exception");

endmodule

bind mem_wb_reg mem_stage_asserts #(
    .NUM_LANES (NUM_LANES)
) u_mem_stage_asserts (
    .clk_i   (clk),
    .rst_i   (rst_i),
    .lanes_i (lanes_i),
    .pause_i (pause_o),
    .wb_i    (wb_o)
);

// File: verification/tb_mem_stage.sv
module tb_mem_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_LANES    = 2;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int RAND_COUNT   = 16;   // extra non-load vectors
    localparam string PATTERN_FILE = "verification/mem_patterns.txt";

    // one vector: lane stimulus, cache answer and the expected response
    typedef struct packed {
        mem_pkg::mem_lane_t [NUM_LANES-1:0]                lanes;
        logic [mem_pkg::XLEN-1:0]                          rdata;
        logic                                              data_ok;
        logic [NUM_LANES-1:0][mem_pkg::XLEN-1:0]           exp_wdata;
        logic                                              exp_pause;
        logic [NUM_LANES-1:0][mem_pkg::EXC_OUT_W-1:0]      exp_exc;
    } vec_t;

    logic                               clk;
    logic                               rst_i;
    mem_pkg::mem_lane_t [NUM_LANES-1:0] lanes_i;
    logic [mem_pkg::XLEN-1:0]           dcache_rdata_i;
    logic                               dcache_data_ok_i;
    logic                               pause_o;
    mem_pkg::wb_lane_t  [NUM_LANES-1:0] wb_o;

    vec_t        vectors[$];
    vec_t        prev;          // vector whose result is on wb_o now
    int          file_count;
    int          checks;
    int          errors;
    bit          vectors_ready;
    logic [31:0] lcg_state = 32'he791;

    mem_stage #(
        .NUM_LANES (NUM_LANES)
    ) UUT (
        .clk              (clk),
        .rst_i            (rst_i),
        .lanes_i          (lanes_i),
        .dcache_rdata_i   (dcache_rdata_i),
        .dcache_data_ok_i (dcache_data_ok_i),
        .pause_o          (pause_o),
        .wb_o             (wb_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // pc and destination register follow the vector index
    function automatic mem_pkg::mem_lane_t make_lane(mem_pkg::mem_op_e op, logic [31:0] addr,
            logic [31:0] wdata, logic [mem_pkg::EXC_W-1:0] exc, logic valid, int idx, int lane);
        mem_pkg::mem_lane_t l;
        l.valid    = valid;
        l.pc       = 32'h0040_0000 + 32'(idx * 8 + lane * 4);
        l.op       = op;
        l.addr     = addr;
        l.rf_we    = valid;
        l.rf_waddr = 5'(idx * 2 + lane + 1);
        l.rf_wdata = wdata;
        l.exc      = exc;
        return l;
    endfunction

    // a paused vector leaves an all-zero bubble
    function automatic mem_pkg::wb_lane_t expected_wb(vec_t v, int lane);
        mem_pkg::wb_lane_t w;
        w = '0;
        if (!v.exp_pause) begin
            w.valid    = v.lanes[lane].valid;
            w.pc       = v.lanes[lane].pc;
            w.addr     = v.lanes[lane].addr;
            w.rf_we    = v.lanes[lane].rf_we;
            w.rf_waddr = v.lanes[lane].rf_waddr;
            w.rf_wdata = v.exp_wdata[lane];
            w.exc      = v.exp_exc[lane];
        end
        return w;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s at %0t: got %h expected %h", name, $time, got, exp);
        end
    endtask

    task automatic check_wb(vec_t v);
        mem_pkg::wb_lane_t exp;
        for (int i = 0; i < NUM_LANES; i++) begin
            exp = expected_wb(v, i);
            check_value($sformatf("wb_o[%0d].valid", i), 32'(wb_o[i].valid), 32'(exp.valid));
            check_value($sformatf("wb_o[%0d].rf_we", i), 32'(wb_o[i].rf_we), 32'(exp.rf_we));
            check_value($sformatf("wb_o[%0d].pc", i), wb_o[i].pc, exp.pc);
            check_value($sformatf("wb_o[%0d].addr", i), wb_o[i].addr, exp.addr);
            check_value($sformatf("wb_o[%0d].rf_waddr", i), 32'(wb_o[i].rf_waddr),
                        32'(exp.rf_waddr));
            check_value($sformatf("wb_o[%0d].rf_wdata", i), wb_o[i].rf_wdata, exp.rf_wdata);
            check_value($sformatf("wb_o[%0d].exc", i), 32'(wb_o[i].exc), 32'(exp.exc));
        end
    endtask

    task automatic read_patterns();
        int          fd;
        int          n;
        int          line_no;
        string       line;
        logic [31:0] f [17];
        vec_t        v;
        line_no = 0;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the pattern file %s", PATTERN_FILE);
            return;
        end
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line[0] == "#") begin
                continue;   // comment or blank line
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
            if (n != 17) begin
                errors++;
                $display("pattern line %0d has %0d fields instead of 17", line_no, n);
                continue;
            end
            v = '0;
            for (int i = 0; i < NUM_LANES; i++) begin
                v.lanes[i] = make_lane(mem_pkg::mem_op_e'(f[5*i][7:0]), f[5*i+1], f[5*i+2],
                                       f[5*i+3][4:0], f[5*i+4][0], vectors.size(), i);
                v.exp_wdata[i] = f[12+i];
                v.exp_exc[i]   = f[15+i][5:0];
            end
            v.rdata     = f[10];
            v.data_ok   = f[11][0];
            v.exp_pause = f[14][0];
            vectors.push_back(v);
        end
        $fclose(fd);
    endtask

    // non-load traffic, the result is the carried rf_wdata
    task automatic add_random_vectors();
        vec_t        v;
        logic [31:0] r;
        for (int k = 0; k < RAND_COUNT; k++) begin
            v = '0;
            r = lcg_next();
            for (int i = 0; i < NUM_LANES; i++) begin
                v.lanes[i] = make_lane(mem_pkg::OP_OTHER, lcg_next(), lcg_next(),
                                       (r[2+i*8 -: 3] == 3'd0) ? r[12+i*8 -: 5] : 5'd0,
                                       r[24+i], vectors.size(), i);
                v.exp_wdata[i] = v.lanes[i].rf_wdata;
                v.exp_exc[i]   = {v.lanes[i].exc, 1'b0};   // commit bit appended low
            end
            v.rdata     = lcg_next();
            v.data_ok   = r[28];
            v.exp_pause = 1'b0;
            vectors.push_back(v);
        end
    endtask

    initial begin
        rst_i            <= 1'b1;
        lanes_i          <= '0;
        dcache_rdata_i   <= '0;
        dcache_data_ok_i <= 1'b0;
        read_patterns();
        file_count = vectors.size();
        add_random_vectors();
        vectors_ready = 1'b1;
        // valid lanes during reset, so only the clear keeps wb_o empty
        for (int i = 0; i < NUM_LANES; i++) begin
            lanes_i[i] <= make_lane(mem_pkg::OP_OTHER, 32'h0, 32'h0, '0, 1'b1, 0, i);
        end

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            for (int i = 0; i < NUM_LANES; i++) begin
                check_value($sformatf("wb_o[%0d].valid", i), 32'(wb_o[i].valid), 32'h0);
                check_value($sformatf("wb_o[%0d].rf_we", i), 32'(wb_o[i].rf_we), 32'h0);
            end
        end
        @(posedge clk);
        rst_i   <= 1'b0;
        lanes_i <= '0;
        prev = '0;  // idle inputs after reset give an empty wb_o

        for (int k = 0; k < vectors.size(); k++) begin
            @(posedge clk);
            lanes_i          <= vectors[k].lanes;
            dcache_rdata_i   <= vectors[k].rdata;
            dcache_data_ok_i <= vectors[k].data_ok;
            @(negedge clk);
            check_value("pause_o", 32'(pause_o), 32'(vectors[k].exp_pause));
            check_wb(prev);
            prev = vectors[k];
        end
        @(posedge clk);
        lanes_i          <= '0;
        dcache_data_ok_i <= 1'b0;
        @(negedge clk);
        check_wb(prev);     // last vector drains

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog sized from the vector count
    initial begin
        int timeout_cycles;
        wait (vectors_ready);
        timeout_cycles = file_count + RAND_COUNT + 20;
        #(timeout_cycles * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: verification/mem_patterns.txt
# op0 addr0 wdata0 exc0 valid0 op1 addr1 wdata1 exc1 valid1 rdata data_ok
# exp_wdata0 exp_wdata1 exp_pause exp_exc0 exp_exc1 (hex, exp_* are wb_o one cycle later)
# byte loads, cache word 80F17F92
20 10000000 AAAA0001 00 1 23 10000001 AAAA0002 00 1 80F17F92 1 FFFFFF92 0000007F 0 00 00
20 10000001 AAAA0003 00 1 23 10000000 AAAA0004 00 1 80F17F92 1 0000007F 00000092 0 00 00
20 10000002 AAAA0005 00 1 23 10000003 AAAA0006 00 1 80F17F92 1 FFFFFFF1 00000080 0 00 00
20 10000003 AAAA0007 00 1 23 10000002 AAAA0008 00 1 80F17F92 1 FFFFFF80 000000F1 0 00 00
# half loads, odd offsets read zero
21 10000000 AAAA0009 00 1 24 10000002 AAAA000A 00 1 80F17F92 1 00007F92 000080F1 0 00 00
21 10000002 AAAA000B 00 1 24 10000000 AAAA000C 00 1 80F17F92 1 FFFF80F1 00007F92 0 00 00
21 10000001 AAAA000D 00 1 24 10000003 AAAA000E 00 1 80F17F92 1 00000000 00000000 0 00 00
21 10000003 AAAA000F 00 1 24 10000001 AAAA0010 00 1 80F17F92 1 00000000 00000000 0 00 00
22 10000004 AAAA0011 00 1 25 10000008 AAAA0012 00 1 80F17F92 1 80F17F92 80F17F92 0 00 00
# cache word 5A3CE601
20 20000001 AAAA0013 00 1 23 20000001 AAAA0014 00 1 5A3CE601 1 FFFFFFE6 000000E6 0 00 00
21 20000000 AAAA0015 00 1 24 20000000 AAAA0016 00 1 5A3CE601 1 FFFFE601 0000E601 0 00 00
21 20000002 AAAA0017 00 1 20 20000002 AAAA0018 00 1 5A3CE601 1 00005A3C 0000003C 0 00 00
23 20000003 AAAA0019 00 1 20 20000000 AAAA001A 00 1 5A3CE601 1 0000005A 00000001 0 00 00
25 20000000 AAAA001B 00 1 22 20000000 AAAA001C 00 1 5A3CE601 1 5A3CE601 5A3CE601 0 00 00
# non-load ops pass rf_wdata whatever data_ok says
00 30000000 12345678 00 1 00 30000004 DEADBEEF 00 1 5A3CE601 1 12345678 DEADBEEF 0 00 00
00 30000008 0BADF00D 00 1 00 3000000C CAFE0123 00 0 5A3CE601 0 0BADF00D CAFE0123 0 00 00
# stall on lane 0, lane 1, both, then two cycles of back-pressure
22 40000000 AAAA001D 00 1 00 40000004 00C0FFEE 00 1 7E57DA7A 0 00000000 00000000 1 00 00
22 40000000 AAAA001D 00 1 00 40000004 00C0FFEE 00 1 7E57DA7A 1 7E57DA7A 00C0FFEE 0 00 00
00 40000008 11112222 00 1 23 40000009 AAAA001E 00 1 7E57DA7A 0 00000000 00000000 1 00 00
00 40000008 11112222 00 1 23 40000009 AAAA001E 00 1 7E57DA7A 1 11112222 000000DA 0 00 00
21 4000000E AAAA001F 00 1 24 4000000C AAAA0020 00 1 7E57DA7A 0 00000000 00000000 1 00 00
21 4000000E AAAA001F 00 1 24 4000000C AAAA0020 00 1 7E57DA7A 1 00007E57 0000DA7A 0 00 00
22 40000010 AAAA0021 00 1 00 40000014 55555555 00 1 13579BDF 0 00000000 00000000 1 00 00
22 40000010 AAAA0021 00 1 00 40000014 55555555 00 1 13579BDF 0 00000000 00000000 1 00 00
22 40000010 AAAA0021 00 1 00 40000014 55555555 00 1 13579BDF 1 13579BDF 55555555 0 00 00
# exceptions override the pause, a waiting load writes zero
22 50000000 AAAA0022 00 1 00 50000004 66667777 04 1 13579BDF 0 00000000 66667777 0 00 08
21 50000002 AAAA0023 11 1 20 50000003 AAAA0024 00 1 13579BDF 0 00000000 00000000 0 22 00
20 50000001 AAAA0025 1F 1 24 50000002 AAAA0026 01 1 13579BDF 1 FFFFFF9B 00001357 0 3E 02
00 50000008 88889999 02 1 25 5000000C AAAA0027 10 1 13579BDF 0 88889999 00000000 0 04 20
# plain word load to close
22 60000000 AAAA0028 00 1 00 60000004 0F0F0F0F 00 1 FFFFFFFF 1 FFFFFFFF 0F0F0F0F 0 00 00

// File: vlog.f
design/mem_pkg.sv
design/load_align.sv
design/mem_wb_reg.sv
design/mem_stage.sv
verification/mem_stage_asserts.sv
verification/tb_mem_stage.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mem_stage
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))
PATTERNS  := verification/mem_patterns.txt

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(PATTERNS)
	./$(SIM_BIN) > $(LOG) 2>&1 || echo "SIMULATION FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
